// File: Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard hdl/*.sv verif/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/arch_rat.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module arch_rat
    import rename_pkg::*;
    import rob_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset_n,
    input  commit_t                           commit0,
    input  commit_t                           commit1,
    output logic [NUM_LREGS-1:0][`PREG_RANGE] arch_map
);

    logic [NUM_LREGS-1:0][`PREG_RANGE] map;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                map[i] <= PREG_W'(i);
            end
        end else begin
            if (commit0.valid && commit0.has_dest) begin
                map[commit0.lrd] <= commit0.prd;
            end
            // Younger commit overrides on a shared lrd
            if (commit1.valid && commit1.has_dest) begin
                map[commit1.lrd] <= commit1.prd;
            end
        end
    end

    assign arch_map = map;

endmodule

// File: hdl/free_list.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module free_list
    import rename_pkg::*;
    import rob_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       rollback,
    input  logic [1:0]                 alloc_cnt,
    input  commit_t                    commit0,
    input  commit_t                    commit1,
    output logic [1:0][`PREG_RANGE]    alloc_preg,
    output logic [FL_PTR_W-1:0]        avail
);

    logic [FREE_DEPTH-1:0][`PREG_RANGE] ring;
    logic [FL_PTR_W-1:0]                spec_head;
    logic [FL_PTR_W-1:0]                commit_head;
    logic [FL_PTR_W-1:0]                tail;
    logic [FL_PTR_W-1:0]                commit_head_nxt;
    logic [FL_PTR_W-1:0]                tail_second;
    logic                               push0;
    logic                               push1;
    logic [FL_PTR_W-1:0]                push_cnt;

    assign push0 = commit0.valid && commit0.has_dest;
    assign push1 = commit1.valid && commit1.has_dest;
    assign push_cnt = FL_PTR_W'(push0) + FL_PTR_W'(push1);
    assign commit_head_nxt = commit_head + push_cnt;
    // commit1 goes behind commit0 only when commit0 pushed
    assign tail_second = tail + FL_PTR_W'(push0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // Registers 32..63 start free while 0..31 are mapped
            for (int i = 0; i < FREE_DEPTH; i++) begin
                ring[i] <= PREG_W'(NUM_LREGS + i);
            end
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= FL_PTR_W'(FREE_DEPTH);
        end else begin
            if (push0) begin
                ring[tail[FL_PTR_W-2:0]] <= commit0.old_prd;
            end
            if (push1) begin
                ring[tail_second[FL_PTR_W-2:0]] <= commit1.old_prd;
            end
            tail        <= tail + push_cnt;
            commit_head <= commit_head_nxt;
            if (rollback) begin
                spec_head <= commit_head_nxt;
            end else begin
                spec_head <= spec_head + FL_PTR_W'(alloc_cnt);
            end
        end
    end

    assign alloc_preg[0] = ring[spec_head[FL_PTR_W-2:0]];
    assign alloc_preg[1] = ring[spec_head[FL_PTR_W-2:0] + 1'b1];
    assign avail = tail - spec_head;

endmodule

// File: hdl/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    localparam int LREG_W       = 5;
    localparam int PREG_W       = 6;
    localparam int NUM_LREGS    = 32;
    localparam int NUM_PREGS    = 64;
    localparam int FREE_DEPTH   = 32;
    // Ring pointers carry one wrap bit above the index
    localparam int FL_PTR_W     = 6;
    localparam int OUT_CREDITS  = 4;
    localparam int IN_CREDITS   = 1;
    localparam int CREDIT_W     = 3;
    // lrs1, lrs2 and lrd for each of the two uops
    localparam int NUM_RD_PORTS = 6;

    typedef struct packed {
        logic              valid;
        logic              has_dest;
        logic [`LREG_RANGE] lrs1;
        logic [`LREG_RANGE] lrs2;
        logic [`LREG_RANGE] lrd;
    } dec_uop_t;

    typedef struct packed {
        dec_uop_t uop1;
        dec_uop_t uop0;
    } dec_pair_t;

    typedef struct packed {
        logic              valid;
        logic              has_dest;
        logic [`LREG_RANGE] lrd;
        logic [`PREG_RANGE] prs1;
        logic [`PREG_RANGE] prs2;
        logic [`PREG_RANGE] prd;
        logic [`PREG_RANGE] old_prd;
    } ren_uop_t;

    typedef struct packed {
        ren_uop_t uop1;
        ren_uop_t uop0;
    } ren_pair_t;

endpackage

// File: hdl/rename_stage.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module rename_stage
    import rename_pkg::*;
    import rob_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  rob_state_e                           rob_state,
    input  dec_pair_t                            in_pair,
    input  logic                                 in_push,
    input  logic                                 out_credit,
    input  logic [NUM_RD_PORTS-1:0][`PREG_RANGE] rd_prs,
    input  logic [1:0][`PREG_RANGE]              alloc_preg,
    input  logic [FL_PTR_W-1:0]                  avail,
    output logic                                 in_credit,
    output ren_pair_t                            out_pair,
    output logic                                 out_valid,
    output logic [NUM_RD_PORTS-1:0][`LREG_RANGE] rd_lrs,
    output logic [1:0]                           wr_en,
    output logic [1:0][`LREG_RANGE]              wr_lrd,
    output logic [1:0][`PREG_RANGE]              wr_prd,
    output logic [1:0]                           alloc_cnt,
    output logic                                 rollback
);

    dec_pair_t           in_q;
    logic                in_full;
    logic [CREDIT_W-1:0] out_cnt;
    logic                dest0;
    logic                dest1;
    logic [1:0]          need_cnt;
    logic                go;
    logic [`PREG_RANGE]  prd0;
    logic [`PREG_RANGE]  prd1;
    ren_pair_t           ren;

    function automatic ren_uop_t build_uop(input dec_uop_t d, input logic dest,
                                           input logic [`PREG_RANGE] prs1,
                                           input logic [`PREG_RANGE] prs2,
                                           input logic [`PREG_RANGE] prd,
                                           input logic [`PREG_RANGE] old_prd);
        ren_uop_t u;
        u.valid    = d.valid;
        u.has_dest = dest;
        u.lrd      = d.lrd;
        u.prs1     = prs1;
        u.prs2     = prs2;
        u.prd      = dest ? prd : '0;
        u.old_prd  = dest ? old_prd : '0;
        return u;
    endfunction

    assign rollback = (rob_state == ROB_ROLLBACK);
    assign dest0    = in_q.uop0.valid && in_q.uop0.has_dest;
    assign dest1    = in_q.uop1.valid && in_q.uop1.has_dest;
    assign need_cnt = {1'b0, dest0} + {1'b0, dest1};

    // Advance needs a held pair, a dispatch slot and enough free registers
    assign go = in_full && !rollback && (out_cnt != '0) && (avail >= FL_PTR_W'(need_cnt));

    assign rd_lrs = {in_q.uop1.lrd, in_q.uop1.lrs2, in_q.uop1.lrs1,
                     in_q.uop0.lrd, in_q.uop0.lrs2, in_q.uop0.lrs1};

    // uop0 takes the first head entry when it has a destination
    assign prd0      = alloc_preg[0];
    assign prd1      = dest0 ? alloc_preg[1] : alloc_preg[0];
    assign wr_en     = {go && dest1, go && dest0};
    assign wr_lrd    = {in_q.uop1.lrd, in_q.uop0.lrd};
    assign wr_prd    = {prd1, prd0};
    assign alloc_cnt = go ? need_cnt : 2'd0;

    assign ren.uop0 = build_uop(in_q.uop0, dest0, rd_prs[0], rd_prs[1], prd0, rd_prs[2]);
    assign ren.uop1 = build_uop(in_q.uop1, dest1, rd_prs[3], rd_prs[4], prd1, rd_prs[5]);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            in_full   <= 1'b0;
            out_valid <= 1'b0;
            in_credit <= 1'b0;
            out_cnt   <= CREDIT_W'(OUT_CREDITS);
        end else begin
            out_valid <= go;
            in_credit <= go;
            if (rollback) begin
                in_full <= 1'b0;
            end else if (in_push) begin
                in_full <= 1'b1;
            end else if (go) begin
                in_full <= 1'b0;
            end
            case ({go, out_credit})
                2'b10:   out_cnt <= out_cnt - 1'b1;
                2'b01:   out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_push) begin
            in_q <= in_pair;
        end
        if (go) begin
            out_pair <= ren;
        end
    end

endmodule

// File: hdl/rename_top.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module rename_top
    import rename_pkg::*;
    import rob_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset_n,
    input  dec_pair_t                         in_pair,
    input  logic                              in_push,
    output logic                              in_credit,
    output ren_pair_t                         out_pair,
    output logic                              out_valid,
    input  logic                              out_credit,
    input  commit_t                           commit0,
    input  commit_t                           commit1,
    input  rob_state_e                        rob_state,
    output logic [NUM_LREGS-1:0][`PREG_RANGE] arch_map
);

    logic [NUM_RD_PORTS-1:0][`LREG_RANGE] rd_lrs;
    logic [NUM_RD_PORTS-1:0][`PREG_RANGE] rd_prs;
    logic [1:0]                           wr_en;
    logic [1:0][`LREG_RANGE]              wr_lrd;
    logic [1:0][`PREG_RANGE]              wr_prd;
    logic [1:0]                           alloc_cnt;
    logic [1:0][`PREG_RANGE]              alloc_preg;
    logic [FL_PTR_W-1:0]                  avail;
    logic                                 rollback;

    rename_stage u_stage (.*);

    spec_rat u_spec_rat (.*);

    arch_rat u_arch_rat (.*);

    free_list u_free_list (.*);

endmodule

// File: hdl/rob_pkg.sv
`include "rename_macros.svh"

package rob_pkg;

    import rename_pkg::*;

    // Only idle and rollback since walk recovery is not modelled
    typedef enum logic [1:0] {
        ROB_IDLE     = 2'd0,
        ROB_ROLLBACK = 2'd1
    } rob_state_e;

    typedef struct packed {
        logic              valid;
        logic              has_dest;
        logic [`LREG_RANGE] lrd;
        logic [`PREG_RANGE] prd;
        logic [`PREG_RANGE] old_prd;
    } commit_t;

endpackage

// File: hdl/spec_rat.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module spec_rat
    import rename_pkg::*;
(
    input  logic                                       clock,
    input  logic                                       reset_n,
    input  logic                                       rollback,
    input  logic [NUM_LREGS-1:0][`PREG_RANGE]          arch_map,
    input  logic [NUM_RD_PORTS-1:0][`LREG_RANGE]       rd_lrs,
    input  logic [1:0]                                 wr_en,
    input  logic [1:0][`LREG_RANGE]                    wr_lrd,
    input  logic [1:0][`PREG_RANGE]                    wr_prd,
    output logic [NUM_RD_PORTS-1:0][`PREG_RANGE]       rd_prs
);

    logic [NUM_LREGS-1:0][`PREG_RANGE] map;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // Identity map out of reset
            for (int i = 0; i < NUM_LREGS; i++) begin
                map[i] <= PREG_W'(i);
            end
        end else if (rollback) begin
            map <= arch_map;
        end else begin
            if (wr_en[0]) begin
                map[wr_lrd[0]] <= wr_prd[0];
            end
            // Port 1 is the younger uop and lands last
            if (wr_en[1]) begin
                map[wr_lrd[1]] <= wr_prd[1];
            end
        end
    end

    // Ports 0..2 belong to uop0 and see the table as it stands
    // Ports 3..5 belong to uop1 and also see the write of uop0
    always_comb begin
        for (int k = 0; k < NUM_RD_PORTS; k++) begin
            rd_prs[k] = map[rd_lrs[k]];
            if (k >= NUM_RD_PORTS / 2 && wr_en[0] && rd_lrs[k] == wr_lrd[0]) begin
                rd_prs[k] = wr_prd[0];
            end
        end
    end

endmodule

// File: include/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Bit ranges of register indices from the rename_pkg widths
`define LREG_RANGE LREG_W-1:0
`define PREG_RANGE PREG_W-1:0

`endif

// File: sim.f
+incdir+include
hdl/rename_pkg.sv
hdl/rob_pkg.sv
hdl/spec_rat.sv
hdl/arch_rat.sv
hdl/free_list.sv
hdl/rename_stage.sv
hdl/rename_top.sv
verif/rename_asserts.sv
verif/rename_tb.sv

// File: verif/rename_asserts.sv
`timescale 1ns/10ps

module rename_asserts
    import rename_pkg::*;
(
    input logic                clock,
    input logic                reset_n,
    input logic                out_valid,
    input logic                out_credit,
    input logic                rollback,
    input logic [FL_PTR_W-1:0] avail
);

    // Dispatch slots counted from the outside
    logic [CREDIT_W-1:0] slots;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            slots <= CREDIT_W'(OUT_CREDITS);
        end else begin
            slots <= slots - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
        end
    end

    valid_needs_slot: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid |-> slots != '0)
        else $error("out_valid without a dispatch slot");

    slots_bounded: assert property (@(posedge clock) disable iff (!reset_n)
        slots <= CREDIT_W'(OUT_CREDITS))
        else $error("dispatch returned more credits than it was given");

    avail_bounded: assert property (@(posedge clock) disable iff (!reset_n)
        avail <= FL_PTR_W'(FREE_DEPTH))
        else $error("free list holds more than its depth");

    // Every uncommitted allocation goes back to the list
    full_after_rollback: assert property (@(posedge clock) disable iff (!reset_n)
        rollback |=> avail == FL_PTR_W'(FREE_DEPTH))
        else $error("free list not full after rollback");

endmodule

// File: verif/rename_tb.sv
`timescale 1ns/10ps

module rename_tb
    import rename_pkg::*;
    import rob_pkg::*;
;

    localparam int NUM_PAIRS = 400;
    localparam int LIMIT     = 8 * NUM_PAIRS + 200;

    logic clock = 1'b0;
    logic reset_n;
    dec_pair_t in_pair;
    logic in_push, in_credit, out_valid, out_credit;
    ren_pair_t out_pair;
    commit_t commit0, commit1;
    rob_state_e rob_state;
    logic [NUM_LREGS-1:0][PREG_W-1:0] arch_map;

    // Reference model state
    logic [NUM_LREGS-1:0][PREG_W-1:0] spec_m, arch_m;
    logic [PREG_W-1:0] fl_q[$];
    int spec_idx, commit_idx;
    dec_pair_t exp_q[$];
    ren_uop_t rob_q[$];
    logic [31:0] lfsr = 32'h61ab1043;
    int cycle, pushed, held, owed;
    logic dec_credit;

    rename_top u_dut (.*);

    bind rename_top rename_asserts u_asserts (.*);

    always #10 clock = ~clock;

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic check_value(input logic [191:0] got, input logic [191:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Renames a pair in program order so uop1 sees the write of uop0
    function automatic ren_pair_t rename_ref(input dec_pair_t d);
        ren_pair_t r;
        ren_uop_t u[2];
        dec_uop_t s[2];
        s[0] = d.uop0;
        s[1] = d.uop1;
        for (int k = 0; k < 2; k++) begin
            u[k].valid    = s[k].valid;
            u[k].has_dest = s[k].valid && s[k].has_dest;
            u[k].lrd      = s[k].lrd;
            u[k].prs1     = spec_m[s[k].lrs1];
            u[k].prs2     = spec_m[s[k].lrs2];
            u[k].prd      = '0;
            u[k].old_prd  = '0;
            if (u[k].has_dest) begin
                u[k].old_prd = spec_m[s[k].lrd];
                u[k].prd = fl_q[spec_idx];
                spec_idx++;
                spec_m[s[k].lrd] = u[k].prd;
            end
        end
        r.uop0 = u[0];
        r.uop1 = u[1];
        return r;
    endfunction

    task automatic apply_commit(output commit_t c);
        ren_uop_t u;
        u = rob_q.pop_front();
        c = '{valid: 1'b1, has_dest: u.has_dest, lrd: u.lrd, prd: u.prd,
              old_prd: u.old_prd};
        if (u.has_dest) begin
            arch_m[u.lrd] = u.prd;
            fl_q.push_back(u.old_prd);
            commit_idx++;
        end
    endtask

    function automatic dec_uop_t make_uop(input int lrs1, input int lrs2, input int lrd);
        return '{valid: 1'b1, has_dest: 1'b1, lrs1: LREG_W'(lrs1), lrs2: LREG_W'(lrs2),
                 lrd: LREG_W'(lrd)};
    endfunction

    function automatic dec_uop_t random_uop();
        return '{valid: take_bits(3) != 0, has_dest: take_bits(2) != 0,
                 lrs1: LREG_W'(take_bits(3)), lrs2: LREG_W'(take_bits(5)),
                 lrd: LREG_W'(take_bits(5))};
    endfunction

    // Compare after the edge has settled
    always @(posedge clock) begin
        ren_pair_t exp;
        #1;
        if (reset_n) begin
            cycle++;
            if (cycle > LIMIT) begin
                $display("Timeout: run did not finish within %0d cycles", LIMIT);
                $display("=== FAIL ===");
                $fatal(1, "timeout");
            end
            check_value(in_credit, out_valid, "in_credit with out_valid");
            if (in_credit) begin
                dec_credit = 1'b1;
            end
            if (out_valid) begin
                check_value(held > 0, 1, "out_valid without a dispatch credit");
                check_value(exp_q.size() != 0, 1, "out_valid without a pending pair");
                exp = rename_ref(exp_q.pop_front());
                check_value(out_pair, exp, "renamed pair");
                held--;
                owed++;
                if (exp.uop0.valid) rob_q.push_back(exp.uop0);
                if (exp.uop1.valid) rob_q.push_back(exp.uop1);
            end
        end
    end

    // Decode, dispatch and ROB stand-ins
    always @(negedge clock) begin
        int n;
        if (reset_n) begin
            check_value(arch_map, arch_m, "architectural map");
            in_push    = 1'b0;
            out_credit = 1'b0;
            commit0    = '0;
            commit1    = '0;
            rob_state  = ROB_IDLE;
            if (pushed > 20 && take_bits(5) == 0) begin
                rob_state  = ROB_ROLLBACK;
                spec_m     = arch_m;
                spec_idx   = commit_idx;
                exp_q.delete();
                rob_q.delete();
                dec_credit = 1'b1;
            end else begin
                if (dec_credit && pushed < NUM_PAIRS && take_bits(1)) begin
                    // Directed pairs lead with fresh destinations before the bypass pair
                    if (pushed == 0) begin
                        in_pair = {make_uop(5, 6, 4), make_uop(2, 3, 1)};
                    end else if (pushed == 1) begin
                        in_pair = {make_uop(9, 10, 7), make_uop(8, 11, 6)};
                    end else if (pushed == 2) begin
                        in_pair = {make_uop(1, 1, 1), make_uop(1, 4, 1)};
                    end else begin
                        in_pair = {random_uop(), random_uop()};
                    end
                    in_push = 1'b1;
                    exp_q.push_back(in_pair);
                    dec_credit = 1'b0;
                    pushed++;
                end
                if (cycle > 40) begin
                    n = take_bits(2);
                    if (n > rob_q.size()) n = rob_q.size();
                    if (n >= 1) apply_commit(commit0);
                    if (n >= 2) apply_commit(commit1);
                end
            end
            // Credits stay withheld early so the counter runs dry
            if (cycle > 60 && owed > 0 && take_bits(1)) begin
                out_credit = 1'b1;
                owed--;
                held++;
            end
        end
    end

    initial begin
        in_pair    = '0;
        in_push    = 1'b0;
        out_credit = 1'b0;
        commit0    = '0;
        commit1    = '0;
        rob_state  = ROB_IDLE;
        reset_n    = 1'b0;
        for (int i = 0; i < NUM_LREGS; i++) begin
            spec_m[i] = PREG_W'(i);
            arch_m[i] = PREG_W'(i);
            fl_q.push_back(PREG_W'(NUM_LREGS + i));
        end
        spec_idx   = 0;
        commit_idx = 0;
        cycle      = 0;
        pushed     = 0;
        held       = OUT_CREDITS;
        owed       = 0;
        dec_credit = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n <= 1'b1;
        while (!(pushed == NUM_PAIRS && exp_q.size() == 0 && dec_credit)) begin
            @(posedge clock);
        end
        repeat (2) @(negedge clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule
